/* common/dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

    // ****************************************
    // buffer geometry
    // ****************************************
    localparam int DATA_WIDTH = 32;
    localparam int NUM_BANKS  = 2;
    localparam int LANE_WIDTH = DATA_WIDTH / NUM_BANKS;
    localparam int ADDR_WIDTH = 6;
    localparam int DEPTH      = 1 << ADDR_WIDTH;

    // highest buffer address, also the post-trigger span at zero pre-trigger
    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(DEPTH - 1);

    // match counter
    localparam int CNT_WIDTH = 4;

    // readout credits
    localparam int CREDIT_MAX   = 4;
    localparam int CREDIT_WIDTH = 3;

    // ****************************************
    // capture FSM encoding
    // ****************************************
    localparam int                    CAP_STATE_WIDTH = 3;
    localparam logic [CAP_STATE_WIDTH-1:0] CAP_IDLE = 3'd0;
    localparam logic [CAP_STATE_WIDTH-1:0] CAP_PRE  = 3'd1;
    localparam logic [CAP_STATE_WIDTH-1:0] CAP_WAIT = 3'd2;
    localparam logic [CAP_STATE_WIDTH-1:0] CAP_POST = 3'd3;
    localparam logic [CAP_STATE_WIDTH-1:0] CAP_DONE = 3'd4;

    // one sample word, seen whole or split into memory lanes
    typedef union packed {
        logic [DATA_WIDTH-1:0]                full;
        logic [NUM_BANKS-1:0][LANE_WIDTH-1:0] lane;
    } dbg_word_u;

endpackage

`default_nettype wire

/* capture_ctrl/capture_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module capture_ctrl (
    input  wire                               clk,
    input  wire                               arst_n,

    // ****************************************
    // host configuration
    // ****************************************
    input  wire                               capture_enable,
    input  wire                               capture_start,
    input  wire  [dbg_pkg::ADDR_WIDTH-1:0]    pre_trigger_num,
    input  wire  [dbg_pkg::DATA_WIDTH-1:0]    trigger_pattern,
    input  wire  [dbg_pkg::DATA_WIDTH-1:0]    trigger_mask,
    input  wire                               cnt_wrap_mode,
    input  wire                               cnt_clr,

    // sample stream
    input  wire  [dbg_pkg::DATA_WIDTH-1:0]    smp_data,
    input  wire                               smp_vld,

    // from readout side
    input  wire                               readout_done,

    // ****************************************
    // status and bank write port
    // ****************************************
    output logic [dbg_pkg::ADDR_WIDTH-1:0]    tri_addr,
    output logic [dbg_pkg::ADDR_WIDTH-1:0]    read_start_addr,
    output logic                              capture_done,
    output logic [dbg_pkg::CNT_WIDTH-1:0]     match_cnt,
    output logic                              bank_wr_en,
    output logic [dbg_pkg::ADDR_WIDTH-1:0]    bank_wr_addr,
    output dbg_pkg::dbg_word_u                bank_wr_data
);

    logic [dbg_pkg::CAP_STATE_WIDTH-1:0] state;
    logic [dbg_pkg::ADDR_WIDTH-1:0]      wr_ptr;
    logic [dbg_pkg::ADDR_WIDTH-1:0]      stored_cnt;
    logic [dbg_pkg::ADDR_WIDTH-1:0]      stored_nxt;
    logic [dbg_pkg::ADDR_WIDTH-1:0]      post_cnt;
    logic                                armed;
    logic                                match_hit;
    logic                                trig_hit;

    // shared by trigger and match counter
    assign match_hit = ((smp_data ^ trigger_pattern) & trigger_mask) == '0;

    assign armed = (state == dbg_pkg::CAP_PRE) || (state == dbg_pkg::CAP_WAIT) ||
                   (state == dbg_pkg::CAP_POST);

    // write lands on the same edge as the sample
    assign bank_wr_en        = armed && capture_enable && smp_vld;
    assign bank_wr_addr      = wr_ptr;
    assign bank_wr_data.full = smp_data;

    assign trig_hit   = bank_wr_en && (state == dbg_pkg::CAP_WAIT) && match_hit;
    assign stored_nxt = stored_cnt + 1'b1;

    assign capture_done = (state == dbg_pkg::CAP_DONE);

    // ****************************************
    // capture sequencing
    // ****************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= dbg_pkg::CAP_IDLE;
            post_cnt <= '0;
        end else begin
            case (state)
                dbg_pkg::CAP_IDLE: begin
                    if (capture_start && capture_enable) begin
                        state <= (pre_trigger_num == '0) ? dbg_pkg::CAP_WAIT : dbg_pkg::CAP_PRE;
                    end
                end
                dbg_pkg::CAP_PRE: begin
                    if (!capture_enable) begin
                        state <= dbg_pkg::CAP_IDLE;
                    end else if (bank_wr_en && (stored_nxt == pre_trigger_num)) begin
                        state <= dbg_pkg::CAP_WAIT;
                    end
                end
                dbg_pkg::CAP_WAIT: begin
                    if (!capture_enable) begin
                        state <= dbg_pkg::CAP_IDLE;
                    end else if (trig_hit) begin
                        // remaining post-trigger samples
                        post_cnt <= dbg_pkg::LAST_ADDR - pre_trigger_num;
                        if (pre_trigger_num == dbg_pkg::LAST_ADDR) begin
                            state <= dbg_pkg::CAP_DONE;
                        end else begin
                            state <= dbg_pkg::CAP_POST;
                        end
                    end
                end
                dbg_pkg::CAP_POST: begin
                    if (!capture_enable) begin
                        state <= dbg_pkg::CAP_IDLE;
                    end else if (bank_wr_en) begin
                        post_cnt <= post_cnt - 1'b1;
                        if (post_cnt == 1) begin
                            state <= dbg_pkg::CAP_DONE;
                        end
                    end
                end
                dbg_pkg::CAP_DONE: begin
                    if (readout_done) begin
                        state <= dbg_pkg::CAP_IDLE;
                    end
                end
                default: state <= dbg_pkg::CAP_IDLE;
            endcase
        end
    end

    // write pointer and pre-trigger fill count, restart from zero while idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            stored_cnt <= '0;
        end else if (state == dbg_pkg::CAP_IDLE) begin
            wr_ptr     <= '0;
            stored_cnt <= '0;
        end else begin
            if (bank_wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (bank_wr_en && (state == dbg_pkg::CAP_PRE)) begin
                stored_cnt <= stored_nxt;
            end
        end
    end

    // trigger location, wraps modulo DEPTH
    always_ff @(posedge clk) begin
        if (trig_hit) begin
            tri_addr        <= wr_ptr;
            read_start_addr <= wr_ptr - pre_trigger_num;
        end
    end

    // ****************************************
    // match counter
    // ****************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            match_cnt <= '0;
        end else if (cnt_clr) begin
            match_cnt <= '0;
        end else if (bank_wr_en && match_hit) begin
            // saturate at all ones unless wrapping
            if (cnt_wrap_mode || (match_cnt != '1)) begin
                match_cnt <= match_cnt + 1'b1;
            end
        end
    end

    // buffer exactly full at capture end, oldest sample sits at the next write slot
    a_full_at_done: assert property (
        @(posedge clk) disable iff (!arst_n)
        capture_done |-> (wr_ptr == read_start_addr)
    );

endmodule

`default_nettype wire

/* design/capture_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module capture_bank (
    input  wire                               clk,

    // write side, from capture
    input  wire                               wr_en,
    input  wire  [dbg_pkg::ADDR_WIDTH-1:0]    wr_addr,
    input  wire  [dbg_pkg::LANE_WIDTH-1:0]    wr_data,

    // read side, to readout
    input  wire                               rd_en,
    input  wire  [dbg_pkg::ADDR_WIDTH-1:0]    rd_addr,
    output logic [dbg_pkg::LANE_WIDTH-1:0]    rd_data
);

    logic [dbg_pkg::LANE_WIDTH-1:0] mem [dbg_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read, data held between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // capture and readout never overlap, so no read-during-write
    a_no_rw_collision: assert property (
        @(posedge clk)
        !(wr_en && rd_en && (wr_addr == rd_addr))
    );

endmodule

`default_nettype wire

/* readout_ctrl/readout_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module readout_ctrl (
    input  wire                               clk,
    input  wire                               arst_n,

    // ****************************************
    // capture status and host control
    // ****************************************
    input  wire                               capture_done,
    input  wire                               readout_start,
    input  wire  [dbg_pkg::ADDR_WIDTH-1:0]    read_start_addr,
    input  wire                               credit_return,

    // bank read port
    input  wire  [dbg_pkg::NUM_BANKS-1:0][dbg_pkg::LANE_WIDTH-1:0] bank_rd_data,
    output logic                              bank_rd_en,
    output logic [dbg_pkg::ADDR_WIDTH-1:0]    bank_rd_addr,

    // ****************************************
    // readout stream
    // ****************************************
    output logic [dbg_pkg::DATA_WIDTH-1:0]    out_data,
    output logic                              out_vld,
    output logic                              readout_done
);

    logic                                busy;
    logic [dbg_pkg::ADDR_WIDTH-1:0]      rd_addr;
    logic [dbg_pkg::ADDR_WIDTH:0]        remain_cnt;
    logic [dbg_pkg::CREDIT_WIDTH-1:0]    credit_cnt;
    logic                                last_vld;
    dbg_pkg::dbg_word_u                  rd_word;

    // read only with words left and a credit in hand
    assign bank_rd_en   = busy && (remain_cnt != '0) && (credit_cnt != '0);
    assign bank_rd_addr = rd_addr;

    // join lanes back into one sample
    always_comb begin
        rd_word.lane = bank_rd_data;
    end
    assign out_data = rd_word.full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            rd_addr    <= '0;
            remain_cnt <= '0;
        end else if (readout_done) begin
            busy <= 1'b0;
        end else if (readout_start && capture_done && !busy) begin
            busy       <= 1'b1;
            rd_addr    <= read_start_addr;
            remain_cnt <= dbg_pkg::DEPTH[dbg_pkg::ADDR_WIDTH:0];
        end else if (bank_rd_en) begin
            // address wraps past the top of the buffer
            rd_addr    <= rd_addr + 1'b1;
            remain_cnt <= remain_cnt - 1'b1;
        end
    end

    // ****************************************
    // credit accounting
    // ****************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= dbg_pkg::CREDIT_MAX[dbg_pkg::CREDIT_WIDTH-1:0];
        end else begin
            case ({credit_return, bank_rd_en})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // valid follows the bank read, done one cycle after the last word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_vld      <= 1'b0;
            last_vld     <= 1'b0;
            readout_done <= 1'b0;
        end else begin
            out_vld      <= bank_rd_en;
            last_vld     <= bank_rd_en && (remain_cnt == 1);
            readout_done <= last_vld;
        end
    end

    // host must not return more credits than words received
    a_credit_max: assert property (
        @(posedge clk) disable iff (!arst_n)
        credit_cnt <= dbg_pkg::CREDIT_MAX
    );

endmodule

`default_nettype wire

/* design/dbg_core.sv */
`timescale 1ns/1ns
`default_nettype none

module dbg_core (
    input  wire                               clk,
    input  wire                               arst_n,

    // sample stream
    input  wire  [dbg_pkg::DATA_WIDTH-1:0]    smp_data,
    input  wire                               smp_vld,

    // ****************************************
    // host configuration
    // ****************************************
    input  wire                               capture_enable,
    input  wire                               capture_start,
    input  wire  [dbg_pkg::ADDR_WIDTH-1:0]    pre_trigger_num,
    input  wire  [dbg_pkg::DATA_WIDTH-1:0]    trigger_pattern,
    input  wire  [dbg_pkg::DATA_WIDTH-1:0]    trigger_mask,
    input  wire                               cnt_wrap_mode,
    input  wire                               cnt_clr,
    input  wire                               readout_start,
    input  wire                               credit_return,

    // ****************************************
    // status and readout stream
    // ****************************************
    output wire  [dbg_pkg::ADDR_WIDTH-1:0]    tri_addr,
    output wire  [dbg_pkg::ADDR_WIDTH-1:0]    read_start_addr,
    output wire                               capture_done,
    output wire  [dbg_pkg::CNT_WIDTH-1:0]     match_cnt,
    output wire  [dbg_pkg::DATA_WIDTH-1:0]    out_data,
    output wire                               out_vld
);

    wire                                                    bank_wr_en;
    wire [dbg_pkg::ADDR_WIDTH-1:0]                          bank_wr_addr;
    dbg_pkg::dbg_word_u                                     bank_wr_data;
    wire                                                    bank_rd_en;
    wire [dbg_pkg::ADDR_WIDTH-1:0]                          bank_rd_addr;
    wire [dbg_pkg::NUM_BANKS-1:0][dbg_pkg::LANE_WIDTH-1:0]  bank_rd_data;
    wire                                                    readout_done;

    capture_ctrl u_capture_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .capture_enable  (capture_enable),
        .capture_start   (capture_start),
        .pre_trigger_num (pre_trigger_num),
        .trigger_pattern (trigger_pattern),
        .trigger_mask    (trigger_mask),
        .cnt_wrap_mode   (cnt_wrap_mode),
        .cnt_clr         (cnt_clr),
        .smp_data        (smp_data),
        .smp_vld         (smp_vld),
        .readout_done    (readout_done),
        .tri_addr        (tri_addr),
        .read_start_addr (read_start_addr),
        .capture_done    (capture_done),
        .match_cnt       (match_cnt),
        .bank_wr_en      (bank_wr_en),
        .bank_wr_addr    (bank_wr_addr),
        .bank_wr_data    (bank_wr_data)
    );

    // one memory per lane, shared addresses
    for (genvar g = 0; g < dbg_pkg::NUM_BANKS; g++) begin : g_bank
        capture_bank u_capture_bank (
            .clk     (clk),
            .wr_en   (bank_wr_en),
            .wr_addr (bank_wr_addr),
            .wr_data (bank_wr_data.lane[g]),
            .rd_en   (bank_rd_en),
            .rd_addr (bank_rd_addr),
            .rd_data (bank_rd_data[g])
        );
    end

    readout_ctrl u_readout_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .capture_done    (capture_done),
        .readout_start   (readout_start),
        .read_start_addr (read_start_addr),
        .credit_return   (credit_return),
        .bank_rd_data    (bank_rd_data),
        .bank_rd_en      (bank_rd_en),
        .bank_rd_addr    (bank_rd_addr),
        .out_data        (out_data),
        .out_vld         (out_vld),
        .readout_done    (readout_done)
    );

endmodule

`default_nettype wire

/* tests/tb_clkgen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for four cycles, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/tb_dbg_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dbg_core;

    localparam logic [31:0] TRIG_PATTERN   = 32'hc3c3_005a;
    localparam logic [31:0] TRIG_MASK      = 32'h0000_00ff;
    localparam int          NUM_TESTS      = 6;
    localparam int          TIMEOUT_CYCLES = 3 * (NUM_TESTS * (dbg_pkg::DEPTH * 4 + 50));

    logic                             clk;
    logic                             arst_n;
    logic [dbg_pkg::DATA_WIDTH-1:0]   smp_data;
    logic                             smp_vld;
    logic                             capture_enable;
    logic                             capture_start;
    logic [dbg_pkg::ADDR_WIDTH-1:0]   pre_trigger_num;
    logic [dbg_pkg::DATA_WIDTH-1:0]   trigger_pattern;
    logic [dbg_pkg::DATA_WIDTH-1:0]   trigger_mask;
    logic                             cnt_wrap_mode;
    logic                             cnt_clr;
    logic                             readout_start;
    logic                             credit_return;
    logic [dbg_pkg::ADDR_WIDTH-1:0]   tri_addr;
    logic [dbg_pkg::ADDR_WIDTH-1:0]   read_start_addr;
    logic                             capture_done;
    logic [dbg_pkg::CNT_WIDTH-1:0]    match_cnt;
    logic [dbg_pkg::DATA_WIDTH-1:0]   out_data;
    logic                             out_vld;

    // sample history, indexed by write address
    logic [31:0] smp_log [dbg_pkg::DEPTH];
    logic [31:0] lfsr = 32'he2ca1037;
    int          smp_idx;
    int          rcv_cnt = 0;
    int          ret_cnt = 0;
    int          ret_issued = 0;
    int          rd_base;
    int          rd_start;
    int          rd_pre;
    int          exp_start;
    int          cycle_cnt = 0;
    int          test_errs = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    bit          hold_credits = 1'b0;
    string       cur_test = "reset";

    tb_clkgen u_clkgen (.clk(clk), .arst_n(arst_n));

    dbg_core u_dut (
        .clk(clk), .arst_n(arst_n), .smp_data(smp_data), .smp_vld(smp_vld),
        .capture_enable(capture_enable), .capture_start(capture_start),
        .pre_trigger_num(pre_trigger_num), .trigger_pattern(trigger_pattern),
        .trigger_mask(trigger_mask), .cnt_wrap_mode(cnt_wrap_mode), .cnt_clr(cnt_clr),
        .readout_start(readout_start), .credit_return(credit_return),
        .tri_addr(tri_addr), .read_start_addr(read_start_addr),
        .capture_done(capture_done), .match_cnt(match_cnt),
        .out_data(out_data), .out_vld(out_vld)
    );

    // ****************************************
    // random source and helpers
    // ****************************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: %s expected %0h actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: passed", cur_test);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", cur_test, test_errs);
        end
    endtask

    // random word kept clear of the trigger condition
    task automatic make_noise(output logic [31:0] d);
        take_bits(32, d);
        if (((d ^ TRIG_PATTERN) & TRIG_MASK) == '0) begin
            d[0] = ~d[0];
        end
    endtask

    task automatic make_match(output logic [31:0] d);
        take_bits(32, d);
        d = (d & ~TRIG_MASK) | (TRIG_PATTERN & TRIG_MASK);
    endtask

    // occasional idle cycle before the sample
    task automatic drive_sample(input logic [31:0] d);
        logic [31:0] gap;
        take_bits(2, gap);
        if (gap[1:0] == 2'b00) begin
            @(negedge clk);
            smp_vld = 1'b0;
        end
        @(negedge clk);
        smp_data = d;
        smp_vld  = 1'b1;
        smp_log[smp_idx % dbg_pkg::DEPTH] = d;
        smp_idx++;
    endtask

    task automatic arm_capture();
        @(negedge clk);
        smp_vld        = 1'b0;
        capture_enable = 1'b1;
        capture_start  = 1'b1;
        @(negedge clk);
        capture_start = 1'b0;
        smp_idx       = 0;
    endtask

    task automatic pulse_clear();
        @(negedge clk);
        cnt_clr = 1'b1;
        @(negedge clk);
        cnt_clr = 1'b0;
    endtask

    // sample index trig matches, and early too if it is not negative
    task automatic run_capture(input logic [dbg_pkg::ADDR_WIDTH-1:0] pre,
                               input int early, input int trig);
        int          total;
        logic [31:0] d;
        total           = trig + dbg_pkg::DEPTH - int'(pre);
        exp_start       = (trig - int'(pre) + dbg_pkg::DEPTH) % dbg_pkg::DEPTH;
        rd_pre          = int'(pre);
        pre_trigger_num = pre;
        arm_capture();
        for (int i = 0; i < total; i++) begin
            if (i == trig || i == early) begin
                make_match(d);
            end else begin
                make_noise(d);
            end
            drive_sample(d);
        end
        @(negedge clk);
        smp_vld = 1'b0;
        check_value("capture_done after last write", 1, capture_done);
    endtask

    task automatic run_readout(input bit withhold);
        rd_start     = exp_start;
        rd_base      = rcv_cnt;
        hold_credits = withhold;
        @(negedge clk);
        readout_start = 1'b1;
        @(negedge clk);
        readout_start = 1'b0;
        if (withhold) begin
            repeat (dbg_pkg::CREDIT_MAX * 4 + 10) @(negedge clk);
            check_value("words while withheld", dbg_pkg::CREDIT_MAX, rcv_cnt - rd_base);
            check_value("out_vld while withheld", 0, out_vld);
            hold_credits = 1'b0;
        end
        while (capture_done) @(negedge clk);
        check_value("words at capture_done fall", dbg_pkg::DEPTH, rcv_cnt - rd_base);
        // let outstanding credits come home
        while (ret_cnt != rcv_cnt) @(negedge clk);
        check_value("total words", dbg_pkg::DEPTH, rcv_cnt - rd_base);
    endtask

    // ****************************************
    // readout monitor and credit host
    // ****************************************
    always @(posedge clk) begin : collect_words
        int widx;
        if (out_vld) begin
            widx = rcv_cnt - rd_base;
            check_value($sformatf("word %0d", widx),
                        smp_log[(rd_start + widx) % dbg_pkg::DEPTH], out_data);
            if (widx == rd_pre) begin
                check_value("trigger word", TRIG_PATTERN & TRIG_MASK, out_data & TRIG_MASK);
            end
            rcv_cnt <= rcv_cnt + 1;
        end
        if (credit_return) begin
            ret_cnt <= ret_cnt + 1;
        end
    end

    initial begin : credit_host
        logic [31:0] dly;
        credit_return = 1'b0;
        forever begin
            @(negedge clk);
            credit_return = 1'b0;
            if (!hold_credits && (rcv_cnt > ret_issued)) begin
                take_bits(2, dly);
                repeat (dly[1:0]) @(negedge clk);
                credit_return = 1'b1;
                ret_issued++;
            end
        end
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        rcv_cnt <= dbg_pkg::CREDIT_MAX + ret_cnt
    ) else begin
        $display("credit flow broken: %0d words received against %0d credits returned",
                 rcv_cnt, ret_cnt);
        test_errs++;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ****************************************
    // test sequence
    // ****************************************
    initial begin : main_seq
        logic [31:0] d;
        smp_data        = '0;
        smp_vld         = 1'b0;
        capture_enable  = 1'b0;
        capture_start   = 1'b0;
        pre_trigger_num = '0;
        trigger_pattern = TRIG_PATTERN;
        trigger_mask    = TRIG_MASK;
        cnt_wrap_mode   = 1'b0;
        cnt_clr         = 1'b0;
        readout_start   = 1'b0;
        @(posedge arst_n);
        @(negedge clk);

        begin_test("reset and disabled start");
        check_value("out_vld", 0, out_vld);
        check_value("capture_done", 0, capture_done);
        check_value("match_cnt", 0, match_cnt);
        capture_start = 1'b1;
        @(negedge clk);
        capture_start = 1'b0;
        // matching samples, so an armed core would finish a capture
        repeat (dbg_pkg::DEPTH + 10) begin
            make_match(d);
            drive_sample(d);
        end
        @(negedge clk);
        smp_vld = 1'b0;
        check_value("capture_done", 0, capture_done);
        check_value("match_cnt after disabled start", 0, match_cnt);
        end_test();

        begin_test("trigger address");
        run_capture(10, -1, 19);
        check_value("tri_addr", 19, tri_addr);
        check_value("read_start_addr", 9, read_start_addr);
        end_test();

        begin_test("readout order");
        run_readout(1'b0);
        end_test();

        begin_test("early match ignored");
        run_capture(8, 7, 70);
        check_value("tri_addr", 6, tri_addr);
        check_value("read_start_addr", 62, read_start_addr);
        end_test();

        begin_test("credit flow");
        run_readout(1'b1);
        end_test();

        begin_test("match counter");
        pre_trigger_num = 40;
        cnt_wrap_mode   = 1'b0;
        pulse_clear();
        arm_capture();
        repeat (20) begin
            make_match(d);
            drive_sample(d);
        end
        @(negedge clk);
        smp_vld = 1'b0;
        check_value("saturated count", 15, match_cnt);
        capture_enable = 1'b0;
        pulse_clear();
        check_value("cleared count", 0, match_cnt);
        cnt_wrap_mode = 1'b1;
        arm_capture();
        repeat (20) begin
            make_match(d);
            drive_sample(d);
        end
        @(negedge clk);
        smp_vld = 1'b0;
        check_value("wrapped count", 4, match_cnt);
        capture_enable = 1'b0;
        pulse_clear();
        check_value("cleared count", 0, match_cnt);
        end_test();

        $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
common/dbg_pkg.sv
capture_ctrl/capture_ctrl.sv
design/capture_bank.sv
readout_ctrl/readout_ctrl.sv
design/dbg_core.sv
tests/tb_clkgen.sv
tests/tb_dbg_core.sv

/* Makefile */
TOP = tb_dbg_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

# status comes from the search for the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
